// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dataCacheTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/apbMemory.sv ====
`timescale 1ns/10ps

module apbMemory import busPkg::*; #(
  parameter logic [31:0] fillPattern = 32'h5a3c96e1
) (
  input  logic       clk,
  input  logic       reset,
  input  apbReqT     apbReq,
  output apbRspT     apbRsp,
  input  logic [1:0] waitStates
);

  // Only written words are stored
  logic [31:0] mem [logic [31:0]];
  logic [1:0] waitCount;
  logic [31:0] readData;
  logic [31:0] wordAddr;

  function automatic logic [31:0] storedWord(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    // Never-written words follow their address
    return addr ^ fillPattern;
  endfunction

  assign wordAddr = {apbReq.paddr[31:2], 2'b00};
  assign apbRsp.pready = apbReq.psel && apbReq.penable && (waitCount == 2'd0);
  assign apbRsp.prdata = readData;

  // Wait count and read data are loaded in the setup phase
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      waitCount <= 2'd0;
      readData <= '0;
    end else if (apbReq.psel && !apbReq.penable) begin
      waitCount <= waitStates;
      readData <= storedWord(wordAddr);
    end else if (apbReq.psel && apbReq.penable && waitCount != 2'd0) begin
      waitCount <= waitCount - 2'd1;
    end
  end

  always @(posedge clk) begin
    logic [31:0] merged;
    if (!reset && apbRsp.pready && apbReq.pwrite) begin
      merged = storedWord(wordAddr);
      for (int b = 0; b < 4; b++) begin
        if (apbReq.pstrb[b]) begin
          merged[8*b +: 8] = apbReq.pwdata[8*b +: 8];
        end
      end
      mem[wordAddr] = merged;
    end
  end

endmodule

// ==== dv/dataCacheTb.sv ====
`timescale 1ns/10ps

module dataCacheTb import cachePkg::*, busPkg::*;;

  localparam int numSets = 4;
  localparam int indexBits = $clog2(numSets);
  localparam logic [31:0] fillPattern = 32'h5a3c96e1;
  localparam int stallLimit = 100;

  logic clk = 1'b0;
  logic reset;
  cpuReqT cpuReq;
  cpuRspT cpuRsp;
  apbReqT apbReq;
  apbRspT apbRsp;
  logic [1:0] waitStates;

  string testName;
  wordT expectData;
  logic expectHit;
  int dataErrors;
  int busErrors;
  logic timedOut;
  logic [31:0] lfsrState = 32'd90225;

  // Expected APB transfers as write flag, address and data
  logic [64:0] xferQ [$];

  // Shadow memory and cache model
  wordT shadow [logic [31:0]];
  logic [numSets-1:0] lruModel;
  logic [1:0] validModel [numSets];
  logic [1:0] dirtyModel [numSets];
  logic [31:0] lineModel [numSets][2];

  dataCache #(.numSets(numSets)) UUT (
    .clk,
    .reset,
    .cpuReq,
    .cpuRsp,
    .apbReq,
    .apbRsp
  );

  apbMemory #(.fillPattern(fillPattern)) memory (
    .clk,
    .reset,
    .apbReq,
    .apbRsp,
    .waitStates
  );

  always #4 clk = ~clk;

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    logic feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      bits = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  function automatic wordT shadowWord(input logic [31:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ fillPattern;
  endfunction

  function automatic wordT mergeBytes(input wordT old, input wordT data, input logic [3:0] mask);
    wordT merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic noteTimeout(input string what);
    $display("Timeout in %s: %s", testName, what);
    timedOut = 1'b1;
  endtask

  // One processor access from request to the cycle stall is low
  task automatic access(input string name, input logic write, input logic [31:0] addr,
                        input wordT data, input logic [3:0] mask);
    logic [31:0] wordAddr;
    logic [31:0] lineAddr;
    logic hit;
    int setIdx;
    int way;
    int cycles;
    if (timedOut) begin
      return;
    end
    wordAddr = {addr[31:2], 2'b00};
    lineAddr = {addr[31:4], 4'b0000};
    setIdx = int'(addr[4 +: indexBits]);
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < 2; w++) begin
      if (validModel[setIdx][w] && lineModel[setIdx][w] == lineAddr) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // Invalid way first and then the least recently used one
      if (!validModel[setIdx][0]) begin
        way = 0;
      end else if (!validModel[setIdx][1]) begin
        way = 1;
      end else begin
        way = int'(lruModel[setIdx]);
      end
      if (validModel[setIdx][way] && dirtyModel[setIdx][way]) begin
        for (int i = 0; i < 4; i++) begin
          xferQ.push_back({1'b1, lineModel[setIdx][way] + 32'(4 * i),
                           shadowWord(lineModel[setIdx][way] + 32'(4 * i))});
        end
      end
      for (int i = 0; i < 4; i++) begin
        xferQ.push_back({1'b0, lineAddr + 32'(4 * i), 32'h0});
      end
    end
    @(posedge clk);
    testName = name;
    expectData <= shadowWord(wordAddr);
    expectHit <= hit;
    cpuReq <= '{read: !write, write: write, addr: addr, writeData: data, byteMask: mask};
    cycles = 0;
    @(negedge clk);
    while (cpuRsp.stall && cycles < stallLimit) begin
      waitStates <= 2'(takeBits(2));
      cycles++;
      @(negedge clk);
    end
    if (cpuRsp.stall) begin
      noteTimeout("stall stayed high");
      return;
    end
    assert (xferQ.size() == 0) else begin
      busErrors++;
      $display("%s: %0d expected APB transfers never happened", name, xferQ.size());
      xferQ.delete();
    end
    if (!hit) begin
      validModel[setIdx][way] = 1'b1;
      dirtyModel[setIdx][way] = 1'b0;
      lineModel[setIdx][way] = lineAddr;
    end
    if (write) begin
      shadow[wordAddr] = mergeBytes(shadowWord(wordAddr), data, mask);
      dirtyModel[setIdx][way] = 1'b1;
    end
    lruModel[setIdx] = (way == 0);
  endtask

  // Every completed APB transfer against the expected list
  always @(negedge clk) begin : transferCheck
    logic [64:0] expected;
    if (!reset && apbReq.psel && apbReq.penable && apbRsp.pready) begin
      if (xferQ.size() == 0) begin
        busErrors++;
        $display("%s: unexpected APB transfer to %h", testName, apbReq.paddr);
      end else begin
        expected = xferQ.pop_front();
        assert ({apbReq.pwrite, apbReq.paddr} == expected[64:32]) else begin
          busErrors++;
          $display("** Error %s: expected write %b addr %h, actual write %b addr %h", testName,
                   expected[64], expected[63:32], apbReq.pwrite, apbReq.paddr);
        end
        assert (!apbReq.pwrite || apbReq.pwdata == expected[31:0]) else begin
          busErrors++;
          $display("** Error %s: expected pwdata %h, actual %h", testName, expected[31:0],
                   apbReq.pwdata);
        end
      end
    end
  end

  readCheck: assert property (@(negedge clk) disable iff (reset)
      (cpuReq.read && !cpuRsp.stall) |-> (cpuRsp.readData == expectData))
    else begin
      dataErrors++;
      $display("** Error %s: expected %h, actual %h", testName, expectData, cpuRsp.readData);
    end

  hitCheck: assert property (@(negedge clk) disable iff (reset)
      (expectHit && (cpuReq.read || cpuReq.write)) |-> (!cpuRsp.stall && !apbReq.psel))
    else begin
      dataErrors++;
      $display("** Error %s: expected stall 0 psel 0, actual stall %b psel %b", testName,
               cpuRsp.stall, apbReq.psel);
    end

  setupCheck: assert property (@(negedge clk) disable iff (reset)
      $rose(apbReq.penable) |-> $past(apbReq.psel && !apbReq.penable))
    else begin
      busErrors++;
      $display("%s: APB access phase without a setup phase", testName);
    end

  accessCheck: assert property (@(negedge clk) disable iff (reset)
      (apbReq.psel && !apbReq.penable) |=> (apbReq.psel && apbReq.penable))
    else begin
      busErrors++;
      $display("%s: APB setup phase not followed by an access phase", testName);
    end

  holdCheck: assert property (@(negedge clk) disable iff (reset)
      (apbReq.psel && !(apbReq.penable && apbRsp.pready))
      |=> $stable({apbReq.paddr, apbReq.pwrite, apbReq.pwdata}))
    else begin
      busErrors++;
      $display("%s: APB request fields changed before pready", testName);
    end

  strobeCheck: assert property (@(negedge clk) disable iff (reset)
      apbReq.psel |-> (apbReq.pstrb == 4'hf))
    else begin
      busErrors++;
      $display("** Error %s: expected pstrb f, actual %h", testName, apbReq.pstrb);
    end

  initial begin
    logic [31:0] lineSel;
    logic [31:0] wordSel;
    logic [31:0] writeSel;
    logic [31:0] randData;
    logic [31:0] randMask;
    int cycles;
    reset = 1'b1;
    cpuReq = '0;
    waitStates = 2'd0;
    expectHit = 1'b0;
    expectData = '0;
    testName = "reset";
    dataErrors = 0;
    busErrors = 0;
    timedOut = 1'b0;
    lruModel = '0;
    for (int s = 0; s < numSets; s++) begin
      validModel[s] = 2'b00;
      dirtyModel[s] = 2'b00;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!apbReq.psel && !apbReq.penable) else begin
      busErrors++;
      $display("** Error reset: expected psel 0 penable 0, actual psel %b penable %b",
               apbReq.psel, apbReq.penable);
    end
    cycles = 0;
    while (cpuRsp.stall && cycles < numSets + 2) begin
      cycles++;
      @(negedge clk);
    end
    if (cpuRsp.stall) begin
      noteTimeout("stall did not fall after the reset sweep");
    end

    // Miss on one line and then hits on all its words
    access("read miss", 1'b0, 32'h0000_1004, '0, 4'h0);
    for (int i = 0; i < 4; i++) begin
      access("read hit", 1'b0, 32'h0000_1000 + 32'(4 * i), '0, 4'h0);
    end

    randMask = takeBits(4);
    randData = takeBits(32);
    access("masked write", 1'b1, 32'h0000_1008, randData, randMask[3:0]);
    access("masked read", 1'b0, 32'h0000_1008, '0, 4'h0);

    // Three tags in set 1 where the written line becomes the victim
    randData = takeBits(32);
    access("dirty write", 1'b1, 32'h0000_2014, randData, 4'hf);
    access("second tag", 1'b0, 32'h0000_2050, '0, 4'h0);
    access("eviction", 1'b0, 32'h0000_2090, '0, 4'h0);
    access("evicted reread", 1'b0, 32'h0000_2014, '0, 4'h0);

    // Eight lines over sets 0 and 2
    for (int n = 0; n < 200; n++) begin
      lineSel = takeBits(3);
      wordSel = takeBits(2);
      writeSel = takeBits(1);
      randData = takeBits(32);
      randMask = takeBits(4);
      access("random", writeSel[0], 32'h0000_4000 + (lineSel << 5) + (wordSel << 2),
             randData, randMask[3:0]);
    end

    @(posedge clk);
    cpuReq <= '0;
    expectHit <= 1'b0;
    @(negedge clk);
    $display("Errors: data %0d, bus %0d, timeout %0d", dataErrors, busErrors, timedOut);
    if (dataErrors == 0 && busErrors == 0 && !timedOut) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/cachePkg.sv
source/busPkg.sv
source/setRam.sv
source/apbMaster.sv
source/cacheController.sv
source/dataCache.sv
dv/apbMemory.sv
dv/dataCacheTb.sv

// ==== source/apbMaster.sv ====
`timescale 1ns/10ps

module apbMaster import busPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  xferReqT xferReq,
  output xferRspT xferRsp,
  output apbReqT  apbReq,
  input  apbRspT  apbRsp
);

  typedef enum logic [1:0] {idle, setup, access} apbStateT;

  apbStateT state;
  logic [apbAddrBits-1:0] addrQ;
  logic [apbDataBits-1:0] wdataQ;
  logic writeQ;
  logic accept;

  // A new transfer is taken only from idle
  assign accept = (state == idle) && xferReq.start;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (xferReq.start) begin
            state <= setup;
          end
        end
        setup: state <= access;
        access: begin
          // Hold the access phase until the slave is ready
          if (apbRsp.pready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Transfer fields captured once per transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      addrQ <= xferReq.addr;
      wdataQ <= xferReq.wdata;
      writeQ <= xferReq.write;
    end
  end

  assign apbReq.psel = (state != idle);
  assign apbReq.penable = (state == access);
  assign apbReq.paddr = addrQ;
  assign apbReq.pwrite = writeQ;
  assign apbReq.pwdata = wdataQ;
  assign apbReq.pstrb = '1;

  // Done marks the completing edge and takes read data straight from the bus
  assign xferRsp.done = (state == access) && apbRsp.pready;
  assign xferRsp.rdata = apbRsp.prdata;

endmodule

// ==== source/busPkg.sv ====
package busPkg;

  localparam int apbAddrBits = 32;
  localparam int apbDataBits = 32;

  typedef struct packed {
    logic [apbAddrBits-1:0]   paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apbDataBits-1:0]   pwdata;
    logic [apbDataBits/8-1:0] pstrb;
  } apbReqT;

  typedef struct packed {
    logic [apbDataBits-1:0] prdata;
    logic                   pready;
  } apbRspT;

  // One word moved between the cache controller and the APB master
  typedef struct packed {
    logic                   start;
    logic                   write;
    logic [apbAddrBits-1:0] addr;
    logic [apbDataBits-1:0] wdata;
  } xferReqT;

  typedef struct packed {
    logic                   done;
    logic [apbDataBits-1:0] rdata;
  } xferRspT;

endpackage

// ==== source/cacheController.sv ====
`timescale 1ns/10ps

module cacheController import cachePkg::*, busPkg::*; #(
  parameter int numSets = 16
) (
  input  logic                                     clk,
  input  logic                                     reset,
  input  cpuReqT                                   cpuReq,
  output cpuRspT                                   cpuRsp,
  input  tagEntryT                                 tagRead0,
  input  tagEntryT                                 tagRead1,
  input  wordT                                     dataRead0,
  input  wordT                                     dataRead1,
  output logic [$clog2(numSets)-1:0]               tagIndex,
  output logic                                     tagWriteEnable0,
  output logic                                     tagWriteEnable1,
  output tagEntryT                                 tagWriteEntry,
  output logic [$clog2(numSets*wordsPerLine)-1:0]  dataAddr,
  output logic                                     dataWriteEnable0,
  output logic                                     dataWriteEnable1,
  output wordT                                     dataWriteWord,
  output xferReqT                                  xferReq,
  input  xferRspT                                  xferRsp
);

  localparam int indexBits = $clog2(numSets);
  localparam int tagUsed = addrBits - lineOffsetBits - indexBits;

  cacheStateT state;
  logic [indexBits-1:0] sweepCount;
  logic [wordOffsetBits-1:0] wordCount;
  logic victimWay;
  // Way to replace next in each set
  logic [numSets-1:0] lru;

  logic [indexBits-1:0] reqIndex;
  logic [wordOffsetBits-1:0] reqWord;
  logic [tagUsed-1:0] reqTag;
  logic [tagUsed-1:0] lineTag;
  logic reqActive;
  logic hit0;
  logic hit1;
  logic hit;
  logic hitWay;
  logic accessDone;
  logic newVictim;
  logic victimSel;
  logic lastWord;
  logic missBusy;
  tagEntryT victimEntry;
  wordT hitWord;
  wordT victimWord;
  wordT mergedWord;

  assign reqIndex = cpuReq.addr[lineOffsetBits +: indexBits];
  assign reqWord = cpuReq.addr[byteOffsetBits +: wordOffsetBits];
  assign reqTag = cpuReq.addr[addrBits-1 -: tagUsed];

  // Only the low tag bits take part in hit detection
  assign reqActive = cpuReq.read | cpuReq.write;
  assign hit0 = tagRead0.valid && (tagRead0.tag[tagUsed-1:0] == reqTag);
  assign hit1 = tagRead1.valid && (tagRead1.tag[tagUsed-1:0] == reqTag);
  assign hit = hit0 | hit1;
  assign hitWay = hit1;
  assign accessDone = reqActive && hit && (state == ready || state == resume);

  // Invalid way first and way 0 if both are free
  always_comb begin
    if (!tagRead0.valid) begin
      newVictim = 1'b0;
    end else if (!tagRead1.valid) begin
      newVictim = 1'b1;
    end else begin
      newVictim = lru[reqIndex];
    end
  end

  assign victimSel = (state == ready) ? newVictim : victimWay;
  assign victimEntry = victimSel ? tagRead1 : tagRead0;
  assign victimWord = victimSel ? dataRead1 : dataRead0;
  assign hitWord = hitWay ? dataRead1 : dataRead0;

  // Byte lanes from the write data replace the hit word
  always_comb begin
    mergedWord = hitWord;
    for (int b = 0; b < wordBits / 8; b++) begin
      if (cpuReq.byteMask[b]) begin
        mergedWord[8*b +: 8] = cpuReq.writeData[8*b +: 8];
      end
    end
  end

  assign lastWord = xferRsp.done && (wordCount == wordOffsetBits'(wordsPerLine - 1));
  assign missBusy = (state == writeBack) || (state == memRead);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= sweep;
      sweepCount <= '0;
      wordCount <= '0;
      victimWay <= 1'b0;
    end else begin
      case (state)
        sweep: begin
          sweepCount <= sweepCount + 1'b1;
          if (sweepCount == indexBits'(numSets - 1)) begin
            state <= ready;
          end
        end
        ready: begin
          if (reqActive && !hit) begin
            victimWay <= newVictim;
            state <= (victimEntry.valid && victimEntry.dirty) ? writeBack : memRead;
          end
        end
        writeBack: begin
          if (lastWord) begin
            state <= memRead;
          end
        end
        memRead: begin
          if (lastWord) begin
            state <= resume;
          end
        end
        resume: state <= ready;
        default: state <= ready;
      endcase
      // Wraps back to word 0 after each line
      if (xferRsp.done) begin
        wordCount <= wordCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lru <= '0;
    end else if (state == sweep) begin
      lru[sweepCount] <= 1'b0;
    end else if (accessDone) begin
      lru[reqIndex] <= ~hitWay;
    end
  end

  // Storage addressing and writes
  always_comb begin
    tagIndex = (state == sweep) ? sweepCount : reqIndex;
    dataAddr = missBusy ? {reqIndex, wordCount} : {reqIndex, reqWord};
    tagWriteEnable0 = 1'b0;
    tagWriteEnable1 = 1'b0;
    tagWriteEntry = '0;
    dataWriteEnable0 = 1'b0;
    dataWriteEnable1 = 1'b0;
    dataWriteWord = mergedWord;
    case (state)
      sweep: begin
        tagWriteEnable0 = 1'b1;
        tagWriteEnable1 = 1'b1;
      end
      memRead: begin
        dataWriteWord = xferRsp.rdata;
        dataWriteEnable0 = xferRsp.done & ~victimWay;
        dataWriteEnable1 = xferRsp.done & victimWay;
        // Line becomes valid and clean with the last word
        tagWriteEntry = '{valid: 1'b1, dirty: 1'b0, tag: tagBits'(reqTag)};
        tagWriteEnable0 = lastWord & ~victimWay;
        tagWriteEnable1 = lastWord & victimWay;
      end
      ready, resume: begin
        if (accessDone && cpuReq.write) begin
          tagWriteEntry = '{valid: 1'b1, dirty: 1'b1, tag: tagBits'(reqTag)};
          tagWriteEnable0 = ~hitWay;
          tagWriteEnable1 = hitWay;
          dataWriteEnable0 = ~hitWay;
          dataWriteEnable1 = hitWay;
        end
      end
      default: begin
        tagWriteEntry = '0;
      end
    endcase
  end

  // Write-back goes to the victim line and refill to the requested line
  assign lineTag = (state == writeBack) ? victimEntry.tag[tagUsed-1:0] : reqTag;
  assign xferReq.start = missBusy;
  assign xferReq.write = (state == writeBack);
  assign xferReq.addr = {lineTag, reqIndex, wordCount, {byteOffsetBits{1'b0}}};
  assign xferReq.wdata = victimWord;

  assign cpuRsp.stall = (state == sweep) || missBusy || (state == ready && reqActive && !hit);
  assign cpuRsp.readData = hitWord;

endmodule

// ==== source/cachePkg.sv ====
package cachePkg;

  // Geometry
  localparam int wordBits = 32;
  localparam int wordsPerLine = 4;
  localparam int addrBits = 32;
  localparam int byteOffsetBits = 2;
  localparam int wordOffsetBits = $clog2(wordsPerLine);
  localparam int lineOffsetBits = wordOffsetBits + byteOffsetBits;

  // Sized for the smallest set count of two so larger caches leave upper bits unused
  localparam int tagBits = addrBits - lineOffsetBits - 1;

  typedef logic [wordBits-1:0] wordT;

  // Processor request held while stall is high
  typedef struct packed {
    logic                read;
    logic                write;
    logic [addrBits-1:0] addr;
    wordT                writeData;
    logic [3:0]          byteMask;
  } cpuReqT;

  typedef struct packed {
    logic stall;
    wordT readData;
  } cpuRspT;

  typedef struct packed {
    logic               valid;
    logic               dirty;
    logic [tagBits-1:0] tag;
  } tagEntryT;

  // Sweep clears the tag arrays after reset
  typedef enum logic [2:0] {sweep, ready, writeBack, memRead, resume} cacheStateT;

endpackage

// ==== source/dataCache.sv ====
`timescale 1ns/10ps

module dataCache import cachePkg::*, busPkg::*; #(
  parameter int numSets = 16
) (
  input  logic   clk,
  input  logic   reset,
  input  cpuReqT cpuReq,
  output cpuRspT cpuRsp,
  output apbReqT apbReq,
  input  apbRspT apbRsp
);

  localparam int dataDepth = numSets * wordsPerLine;

  logic [$clog2(numSets)-1:0] tagIndex;
  logic [$clog2(dataDepth)-1:0] dataAddr;
  logic tagWriteEnable0;
  logic tagWriteEnable1;
  logic dataWriteEnable0;
  logic dataWriteEnable1;
  tagEntryT tagWriteEntry;
  tagEntryT tagRead0;
  tagEntryT tagRead1;
  wordT dataWriteWord;
  wordT dataRead0;
  wordT dataRead1;
  xferReqT xferReq;
  xferRspT xferRsp;

  cacheController #(
    .numSets(numSets)
  ) controller (
    .clk,
    .reset,
    .cpuReq,
    .cpuRsp,
    .tagRead0,
    .tagRead1,
    .dataRead0,
    .dataRead1,
    .tagIndex,
    .tagWriteEnable0,
    .tagWriteEnable1,
    .tagWriteEntry,
    .dataAddr,
    .dataWriteEnable0,
    .dataWriteEnable1,
    .dataWriteWord,
    .xferReq,
    .xferRsp
  );

  // Tag arrays with one entry per set
  setRam #(.entryT(tagEntryT), .depth(numSets)) tagWay0 (
    .clk,
    .reset,
    .readAddr(tagIndex),
    .writeAddr(tagIndex),
    .writeEnable(tagWriteEnable0),
    .writeEntry(tagWriteEntry),
    .readEntry(tagRead0)
  );

  setRam #(.entryT(tagEntryT), .depth(numSets)) tagWay1 (
    .clk,
    .reset,
    .readAddr(tagIndex),
    .writeAddr(tagIndex),
    .writeEnable(tagWriteEnable1),
    .writeEntry(tagWriteEntry),
    .readEntry(tagRead1)
  );

  // Data arrays addressed by set and word
  setRam #(.entryT(wordT), .depth(dataDepth)) dataWay0 (
    .clk,
    .reset,
    .readAddr(dataAddr),
    .writeAddr(dataAddr),
    .writeEnable(dataWriteEnable0),
    .writeEntry(dataWriteWord),
    .readEntry(dataRead0)
  );

  setRam #(.entryT(wordT), .depth(dataDepth)) dataWay1 (
    .clk,
    .reset,
    .readAddr(dataAddr),
    .writeAddr(dataAddr),
    .writeEnable(dataWriteEnable1),
    .writeEntry(dataWriteWord),
    .readEntry(dataRead1)
  );

  apbMaster master (
    .clk,
    .reset,
    .xferReq,
    .xferRsp,
    .apbReq,
    .apbRsp
  );

endmodule

// ==== source/setRam.sv ====
`timescale 1ns/10ps

module setRam #(
  parameter type entryT = logic [31:0],
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [$clog2(depth)-1:0] readAddr,
  input  logic [$clog2(depth)-1:0] writeAddr,
  input  logic                     writeEnable,
  input  entryT                    writeEntry,
  output entryT                    readEntry
);

  entryT mem [depth];

  // Read port is combinational
  assign readEntry = mem[readAddr];

  // Reset clears every entry
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (writeEnable) begin
      mem[writeAddr] <= writeEntry;
    end
  end

endmodule
